// File: source/controlPkg.sv
package controlPkg;

    localparam int opcodeWidth = 6;
    localparam int aluOpWidth  = 6;
    localparam int stepWidth   = 3;

    // Opcode field values
    localparam logic [opcodeWidth-1:0] opcodeRType = 6'b000000;
    localparam logic [opcodeWidth-1:0] opcodeAddi  = 6'b001000;
    localparam logic [opcodeWidth-1:0] opcodeBeq   = 6'b000100;
    localparam logic [opcodeWidth-1:0] opcodeBne   = 6'b000101;
    localparam logic [opcodeWidth-1:0] opcodeBle   = 6'b000110;
    localparam logic [opcodeWidth-1:0] opcodeBgt   = 6'b000111;
    localparam logic [opcodeWidth-1:0] opcodeReset = 6'b111111;

    // Funct field values for R-type
    localparam logic [opcodeWidth-1:0] functAdd = 6'b100000;

    // ALU operation codes
    localparam logic [aluOpWidth-1:0] aluOpAdd     = 6'b100000;
    localparam logic [aluOpWidth-1:0] aluOpCompare = 6'b000111;

    localparam logic [stepWidth-1:0] fetchSteps = 3'd6;

    typedef struct packed {
        logic [opcodeWidth-1:0] opcode;
        logic [4:0]             rs;
        logic [4:0]             rt;
        logic [4:0]             rd;
        logic [4:0]             shamt;
        logic [opcodeWidth-1:0] funct;
    } rTypeFields;

    typedef struct packed {
        logic [opcodeWidth-1:0] opcode;
        logic [4:0]             rs;
        logic [4:0]             rt;
        logic [15:0]            immediate;
    } iTypeFields;

    // Same 32 bits seen as R-type or I-type
    typedef union packed {
        rTypeFields rType;
        iTypeFields iType;
    } instructionWord;

    typedef enum logic [2:0] {
        classAdd,
        classAddi,
        classBranch,
        classReset,
        classUnknown
    } instructionClass;

    // Comparison the datapath uses to gate pcWriteCond
    typedef enum logic [1:0] {
        testEqual,
        testNotEqual,
        testLessEqual,
        testGreater
    } branchTest;

    typedef enum logic [1:0] {
        srcRegB      = 2'b00,
        srcFour      = 2'b01,
        srcImmediate = 2'b10
    } aluSourceB;

    typedef enum logic [1:0] {
        destRt = 2'b00,
        destRd = 2'b01
    } registerDest;

    typedef enum logic [1:0] {
        phaseResetHold,
        phaseFetch,
        phaseExecute
    } phase;

    typedef struct packed {
        phase                  currentPhase;
        instructionClass       instrClass;
        branchTest             branchSel;
        logic [stepWidth-1:0]  step;
    } sequencerState;

    typedef struct packed {
        logic                  pcWrite;
        logic                  pcWriteCond;
        logic                  irWrite;
        logic                  abWrite;
        logic                  aluOutWrite;
        logic                  regWrite;
        logic                  resetOut;
        logic                  aluSrcA;
        aluSourceB             aluSrcB;
        registerDest           regDst;
        branchTest             branchSel;
        logic [aluOpWidth-1:0] aluOp;
    } controlWord;

    // Execute steps per instruction class
    function automatic logic [stepWidth-1:0] execSteps(instructionClass instrClass);
        case (instrClass)
            classAdd:    return 3'd2;
            classAddi:   return 3'd2;
            classBranch: return 3'd1;
            classReset:  return 3'd1;
            default:     return 3'd0;
        endcase
    endfunction

endpackage

// File: source/instructionDecoder.sv
`timescale 1ns/1ps

module instructionDecoder (
    input  controlPkg::instructionWord  instruction,
    output controlPkg::instructionClass instrClass,
    output controlPkg::branchTest       branchSel
);

    import controlPkg::*;

    always_comb begin
        instrClass = classUnknown;
        branchSel  = testEqual;

        case (instruction.iType.opcode)
            opcodeRType: begin
                // Only add is supported among R-type
                if (instruction.rType.funct == functAdd) begin
                    instrClass = classAdd;
                end
            end
            opcodeAddi: begin
                instrClass = classAddi;
            end
            opcodeBeq: begin
                instrClass = classBranch;
                branchSel  = testEqual;
            end
            opcodeBne: begin
                instrClass = classBranch;
                branchSel  = testNotEqual;
            end
            opcodeBle: begin
                instrClass = classBranch;
                branchSel  = testLessEqual;
            end
            opcodeBgt: begin
                instrClass = classBranch;
                branchSel  = testGreater;
            end
            opcodeReset: begin
                instrClass = classReset;
            end
            default: begin
                instrClass = classUnknown;
            end
        endcase
    end

endmodule

// File: source/stepSequencer.sv
`timescale 1ns/1ps

module stepSequencer (
    input  logic                        clock,
    input  logic                        reset,
    input  controlPkg::instructionClass instrClass,
    input  controlPkg::branchTest       branchSel,
    output controlPkg::sequencerState   state
);

    import controlPkg::*;

    logic [stepWidth-1:0] lastExecStep;
    logic                 fetchDone;
    logic                 execDone;

    // Class is decoded from the live instruction at the end of fetch
    assign fetchDone    = (state.step == fetchSteps - 1'b1);
    assign lastExecStep = execSteps(state.instrClass) - 1'b1;
    assign execDone     = (state.step == lastExecStep);

    always_ff @(posedge clock) begin
        if (reset) begin
            state.currentPhase <= phaseResetHold;
            state.instrClass   <= classUnknown;
            state.branchSel    <= testEqual;
            state.step         <= '0;
        end else begin
            case (state.currentPhase)
                phaseResetHold: begin
                    state.currentPhase <= phaseFetch;
                    state.step         <= '0;
                end

                phaseFetch: begin
                    if (fetchDone) begin
                        state.instrClass <= instrClass;
                        state.branchSel  <= branchSel;
                        state.step       <= '0;
                        // Unknown opcodes skip execute entirely
                        if (execSteps(instrClass) == '0) begin
                            state.currentPhase <= phaseFetch;
                        end else begin
                            state.currentPhase <= phaseExecute;
                        end
                    end else begin
                        state.step <= state.step + 1'b1;
                    end
                end

                phaseExecute: begin
                    if (execDone) begin
                        state.currentPhase <= phaseFetch;
                        state.step         <= '0;
                    end else begin
                        state.step <= state.step + 1'b1;
                    end
                end

                default: begin
                    state.currentPhase <= phaseResetHold;
                    state.step         <= '0;
                end
            endcase
        end
    end

endmodule

// File: source/controlWordEncoder.sv
`timescale 1ns/1ps

module controlWordEncoder (
    input  controlPkg::sequencerState state,
    output controlPkg::controlWord    control
);

    import controlPkg::*;

    always_comb begin
        control = '0;

        case (state.currentPhase)
            phaseResetHold: begin
                control.resetOut = 1'b1;
            end

            phaseFetch: begin
                case (state.step)
                    3'd0, 3'd1, 3'd2: begin
                        // PC + 4 while memory is read
                        control.aluOp   = aluOpAdd;
                        control.aluSrcB = srcFour;
                    end
                    3'd3: begin
                        control.pcWrite = 1'b1;
                        control.irWrite = 1'b1;
                    end
                    3'd4: begin
                        control.abWrite = 1'b1;
                    end
                    default: begin
                        control = '0;
                    end
                endcase
            end

            phaseExecute: begin
                case (state.instrClass)
                    classAdd, classAddi: begin
                        if (state.step == 3'd0) begin
                            control.aluOutWrite = 1'b1;
                            control.aluSrcA     = 1'b1;
                            control.aluOp       = aluOpAdd;
                            if (state.instrClass == classAdd) begin
                                control.aluSrcB = srcRegB;
                            end else begin
                                control.aluSrcB = srcImmediate;
                            end
                        end else begin
                            // Write back from ALUOut
                            control.regWrite = 1'b1;
                            if (state.instrClass == classAdd) begin
                                control.regDst = destRd;
                            end else begin
                                control.regDst = destRt;
                            end
                        end
                    end

                    classBranch: begin
                        control.pcWriteCond = 1'b1;
                        control.aluSrcA     = 1'b1;
                        control.aluOp       = aluOpCompare;
                        control.branchSel   = state.branchSel;
                    end

                    classReset: begin
                        control.resetOut = 1'b1;
                    end

                    default: begin
                        control = '0;
                    end
                endcase
            end

            default: begin
                control = '0;
            end
        endcase
    end

endmodule

// File: source/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic                       clock,
    input  logic                       reset,
    input  controlPkg::instructionWord instruction,
    output controlPkg::controlWord     control
);

    import controlPkg::*;

    instructionClass decodedClass;
    branchTest       decodedBranch;
    sequencerState   state;

    instructionDecoder decoder0 (
        .instruction (instruction),
        .instrClass  (decodedClass),
        .branchSel   (decodedBranch)
    );

    stepSequencer sequencer0 (
        .clock      (clock),
        .reset      (reset),
        .instrClass (decodedClass),
        .branchSel  (decodedBranch),
        .state      (state)
    );

    // Moore outputs from the registered state
    controlWordEncoder encoder0 (
        .state   (state),
        .control (control)
    );

endmodule

// File: test/controlUnit_props.sv
`timescale 1ns/1ps

module controlUnitProps (
    input logic                   clock,
    input logic                   reset,
    input controlPkg::controlWord control
);

    logic datapathStrobes;

    // Everything that touches the datapath except resetOut
    assign datapathStrobes = control.pcWrite | control.pcWriteCond | control.irWrite
                           | control.abWrite | control.aluOutWrite | control.regWrite;

    pcWriteWithIr: assert property (
        @(posedge clock) disable iff (reset) control.pcWrite |-> control.irWrite
    ) else $error("pcWrite high without irWrite");

    noCondWithRegWrite: assert property (
        @(posedge clock) disable iff (reset) !(control.pcWriteCond && control.regWrite)
    ) else $error("pcWriteCond and regWrite high in the same cycle");

    // Synchronous reset shows in the state one edge later
    quietInReset: assert property (
        @(posedge clock) reset |=> !datapathStrobes
    ) else $error("Datapath strobe high during reset hold");

    regWriteAfterAluOut: assert property (
        @(posedge clock) disable iff (reset) control.regWrite |-> $past(control.aluOutWrite)
    ) else $error("regWrite not preceded by aluOutWrite");

endmodule

bind controlUnit controlUnitProps props0 (
    .clock   (clock),
    .reset   (reset),
    .control (control)
);

// File: test/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb;

    import controlPkg::*;

    localparam int clockPeriod = 4;
    localparam int resetCycles = 5;
    localparam int randomCount = 40;
    // Reset test, add, addi, branches, reset and unknown, worst-case random mix
    localparam int plannedCycles = 14 + 16 + 14 + 28 + 19 + randomCount * 8;

    logic           clock;
    logic           reset;
    instructionWord instruction;
    controlWord     control;

    controlWord expectedSeq[$];
    integer     seed = 14456;
    int         cycleCount = 0;
    int         lastPcWrite = -1;
    int         previousLength = 0;

    controlUnit dut0 (
        .clock       (clock),
        .reset       (reset),
        .instruction (instruction),
        .control     (control)
    );

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    initial begin
        #(plannedCycles * 2 * clockPeriod);
        $display("Watchdog expired before all tests had finished");
        abortRun();
    end

    task automatic abortRun();
        $display("Verification failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkWord(string testName, controlWord expected, controlWord actual);
        if (actual !== expected) begin
            $display("ERR %s: expected control %h actual %h", testName, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkBranch(string testName, branchTest expected, branchTest actual);
        if (actual !== expected) begin
            $display("ERR %s: expected branchSel %s actual %b", testName, expected.name(),
                     actual);
            abortRun();
        end
    endtask

    task automatic checkDest(string testName, registerDest expected, registerDest actual);
        if (actual !== expected) begin
            $display("ERR %s: expected regDst %s actual %b", testName, expected.name(),
                     actual);
            abortRun();
        end
    endtask

    task automatic checkCount(string testName, int expected, int actual);
        if (actual != expected) begin
            $display("ERR %s: expected pcWrite interval %0d actual %0d", testName,
                     expected, actual);
            abortRun();
        end
    endtask

    function automatic instructionWord makeRType(logic [4:0] rs, logic [4:0] rt,
                                                 logic [4:0] rd, logic [5:0] funct);
        instructionWord word;
        word.rType.opcode = opcodeRType;
        word.rType.rs     = rs;
        word.rType.rt     = rt;
        word.rType.rd     = rd;
        word.rType.shamt  = '0;
        word.rType.funct  = funct;
        return word;
    endfunction

    function automatic instructionWord makeIType(logic [5:0] opcode, logic [4:0] rs,
                                                 logic [4:0] rt, logic [15:0] imm);
        instructionWord word;
        word.iType.opcode    = opcode;
        word.iType.rs        = rs;
        word.iType.rt        = rt;
        word.iType.immediate = imm;
        return word;
    endfunction

    function automatic logic [5:0] branchOpcodeFor(branchTest test);
        case (test)
            testEqual:     return opcodeBeq;
            testNotEqual:  return opcodeBne;
            testLessEqual: return opcodeBle;
            default:       return opcodeBgt;
        endcase
    endfunction

    function automatic bit isDefinedOpcode(logic [5:0] opcode);
        return opcode inside {opcodeRType, opcodeAddi, opcodeBeq, opcodeBne,
                              opcodeBle, opcodeBgt, opcodeReset};
    endfunction

    // Expected words of one instruction, fetch then execute
    task automatic buildSequence(instructionClass expClass, branchTest expTest);
        controlWord word;
        expectedSeq.delete();
        for (int s = 0; s < 6; s++) begin
            word = '0;
            if (s < 3) begin
                word.aluOp   = aluOpAdd;
                word.aluSrcB = srcFour;
            end else if (s == 3) begin
                word.pcWrite = 1'b1;
                word.irWrite = 1'b1;
            end else if (s == 4) begin
                word.abWrite = 1'b1;
            end
            expectedSeq.push_back(word);
        end
        if (expClass == classAdd || expClass == classAddi) begin
            word             = '0;
            word.aluOutWrite = 1'b1;
            word.aluSrcA     = 1'b1;
            word.aluOp       = aluOpAdd;
            if (expClass == classAdd) begin
                word.aluSrcB = srcRegB;
            end else begin
                word.aluSrcB = srcImmediate;
            end
            expectedSeq.push_back(word);
            word          = '0;
            word.regWrite = 1'b1;
            if (expClass == classAdd) begin
                word.regDst = destRd;
            end else begin
                word.regDst = destRt;
            end
            expectedSeq.push_back(word);
        end else if (expClass == classBranch) begin
            word             = '0;
            word.pcWriteCond = 1'b1;
            word.aluSrcA     = 1'b1;
            word.aluOp       = aluOpCompare;
            word.branchSel   = expTest;
            expectedSeq.push_back(word);
        end else if (expClass == classReset) begin
            word          = '0;
            word.resetOut = 1'b1;
            expectedSeq.push_back(word);
        end
    endtask

    // Starts on a falling edge with the DUT in fetch step 0
    task automatic runInstruction(string testName, instructionWord instr,
                                  instructionClass expClass, branchTest expTest);
        string cycleName;
        int    length;
        buildSequence(expClass, expTest);
        length      = expectedSeq.size();
        instruction = instr;
        for (int i = 0; i < length; i++) begin
            cycleName = $sformatf("%s cycle %0d", testName, i);
            if (control.pcWrite === 1'b1) begin
                if (lastPcWrite >= 0) begin
                    checkCount(cycleName, previousLength, cycleCount - lastPcWrite);
                end
                lastPcWrite = cycleCount;
            end
            checkWord(cycleName, expectedSeq[i], control);
            if (expectedSeq[i].regWrite) begin
                checkDest(cycleName, expectedSeq[i].regDst, control.regDst);
            end
            if (expectedSeq[i].pcWriteCond) begin
                checkBranch(cycleName, expTest, control.branchSel);
            end
            cycleCount++;
            @(negedge clock);
        end
        previousLength = length;
    endtask

    task automatic testResetHold();
        controlWord holdWord;
        holdWord          = '0;
        holdWord.resetOut = 1'b1;
        for (int i = 0; i < resetCycles; i++) begin
            @(negedge clock);
            checkWord($sformatf("resetHold cycle %0d", i), holdWord, control);
        end
        reset = 1'b0;
        // Release edge enters fetch step 0
        @(negedge clock);
        runInstruction("resetHold", makeRType(5'd1, 5'd2, 5'd3, functAdd), classAdd,
                       testEqual);
    endtask

    task automatic testAdd();
        runInstruction("add", makeRType(5'd4, 5'd5, 5'd6, functAdd), classAdd, testEqual);
        runInstruction("add", makeRType(5'd31, 5'd0, 5'd17, functAdd), classAdd, testEqual);
    endtask

    task automatic testAddi();
        runInstruction("addi", makeIType(opcodeAddi, 5'd7, 5'd8, 16'hfffc), classAddi,
                       testEqual);
        // sub is not decoded here
        runInstruction("rTypeOther", makeRType(5'd1, 5'd2, 5'd3, 6'h22), classUnknown,
                       testEqual);
    endtask

    task automatic testBranches();
        branchTest test;
        for (int t = 0; t < 4; t++) begin
            test = branchTest'(t);
            runInstruction($sformatf("branch %s", test.name()),
                           makeIType(branchOpcodeFor(test), 5'd9, 5'd10, 16'h0010),
                           classBranch, test);
        end
    endtask

    task automatic testResetAndUnknown();
        runInstruction("resetOpcode", makeIType(opcodeReset, 5'd0, 5'd0, 16'h0000),
                       classReset, testEqual);
        runInstruction("unknownLw", makeIType(6'h23, 5'd1, 5'd2, 16'h0004), classUnknown,
                       testEqual);
        runInstruction("unknownJ", makeIType(6'h02, 5'd3, 5'd4, 16'h1234), classUnknown,
                       testEqual);
    endtask

    task automatic testRandomMix();
        int          pick;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [5:0]  field;
        logic [15:0] imm;
        branchTest   test;
        string       name;
        for (int n = 0; n < randomCount; n++) begin
            pick  = $unsigned($random(seed)) % 9;
            rs    = 5'($random(seed));
            rt    = 5'($random(seed));
            rd    = 5'($random(seed));
            field = 6'($random(seed));
            imm   = 16'($random(seed));
            name  = $sformatf("randomMix %0d", n);
            case (pick)
                0: runInstruction(name, makeRType(rs, rt, rd, functAdd), classAdd, testEqual);
                1: runInstruction(name, makeIType(opcodeAddi, rs, rt, imm), classAddi,
                                  testEqual);
                2, 3, 4, 5: begin
                    test = branchTest'(pick - 2);
                    runInstruction(name, makeIType(branchOpcodeFor(test), rs, rt, imm),
                                   classBranch, test);
                end
                6: runInstruction(name, makeIType(opcodeReset, rs, rt, imm), classReset,
                                  testEqual);
                7: begin
                    if (field == functAdd) begin
                        field = 6'h22;
                    end
                    runInstruction(name, makeRType(rs, rt, rd, field), classUnknown, testEqual);
                end
                default: begin
                    if (isDefinedOpcode(field)) begin
                        field = 6'h23;
                    end
                    runInstruction(name, makeIType(field, rs, rt, imm), classUnknown,
                                   testEqual);
                end
            endcase
        end
    endtask

    initial begin
        reset       = 1'b1;
        instruction = '0;
        testResetHold();
        testAdd();
        testAddi();
        testBranches();
        testResetAndUnknown();
        testRandomMix();
        $display("Verification passed");
        $finish;
    end

endmodule

// File: list.f
source/controlPkg.sv
source/instructionDecoder.sv
source/stepSequencer.sv
source/controlWordEncoder.sv
source/controlUnit.sv
test/controlUnit_props.sv
test/controlUnitTb.sv

// File: Bender.yml
package:
  name: control_unit

sources:
  - files:
      - source/controlPkg.sv
      - source/instructionDecoder.sv
      - source/stepSequencer.sv
      - source/controlWordEncoder.sv
      - source/controlUnit.sv
  - target: test
    files:
      - test/controlUnit_props.sv
      - test/controlUnitTb.sv
